// ==== Bender.yml ====
package:
  name: systolic_matmul

sources:
  - systolic_pkg.sv
  - systolic_pe.sv
  - systolic_array.sv
  - operand_skewer.sv
  - result_deskewer.sv
  - matmul_ctrl.sv
  - systolic_wb_top.sv
  - target: test
    files:
      - systolic_assertions.sv
      - tb_systolic.sv

// ==== compile.f ====
systolic_pkg.sv
systolic_pe.sv
systolic_array.sv
operand_skewer.sv
result_deskewer.sv
matmul_ctrl.sv
systolic_wb_top.sv
systolic_assertions.sv
tb_systolic.sv

// ==== matmul_ctrl.sv ====
module matmul_ctrl #(
    parameter int n = 2
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [systolic_pkg::adr_w-1:0]      wb_adr,        // word address
    input  logic [systolic_pkg::bus_w-1:0]      wb_dat_w,
    output logic [systolic_pkg::bus_w-1:0]      wb_dat_r,
    output logic                                wb_ack,
    output logic                                load_weight,   // one-cycle copy into the PEs
    output logic [n*n*systolic_pkg::data_w-1:0] weights_flat,
    output logic                                vec_valid,     // activation row to the skewer
    output logic [n*systolic_pkg::data_w-1:0]   vec_data,
    input  logic                                res_valid,     // aligned result row
    input  logic [n*systolic_pkg::acc_w-1:0]    res_data
);
    import systolic_pkg::*;

    localparam int cells  = n * n;
    localparam int cell_w = $clog2(cells);
    localparam int idx_w  = (n > 1) ? $clog2(n) : 1;

    logic [data_w-1:0] weight_bank [cells];   // staging, copied on load
    logic [data_w-1:0] input_bank  [cells];   // X, row-major
    logic [acc_w-1:0]  result_bank [cells];   // Y, row-major

    ctrl_state_e      state;
    logic [idx_w-1:0] row_idx;                // next X row to stream
    logic [idx_w-1:0] res_idx;                // next Y row to fill
    logic             busy;
    logic             done;

    logic             xfer;                   // first cycle of a transfer
    logic             wr_en;
    logic             start_cmd;
    logic             load_cmd;
    logic [adr_w-1:0] w_off, x_off, y_off;    // offsets into each bank
    logic             hit_w, hit_x, hit_y;
    logic [bus_w-1:0] status_word;

    assign xfer  = wb_cyc && wb_stb && !wb_ack;   // ack drops for a cycle between beats
    assign wr_en = xfer && wb_we;
    assign busy  = (state != idle);

    // addresses below a base wrap to large offsets, so one compare decodes each bank
    assign w_off = wb_adr - base_weight;
    assign x_off = wb_adr - base_input;
    assign y_off = wb_adr - base_result;
    assign hit_w = (w_off < adr_w'(cells));
    assign hit_x = (x_off < adr_w'(cells));
    assign hit_y = (y_off < adr_w'(cells));

    // commands self-clear, dropped while a run is in flight
    assign start_cmd = wr_en && (wb_adr == reg_ctrl) && wb_dat_w[ctrl_start_bit] && !busy;
    assign load_cmd  = wr_en && (wb_adr == reg_ctrl) && wb_dat_w[ctrl_load_bit] && !busy;

    always_comb begin
        status_word                = '0;
        status_word[stat_busy_bit] = busy;
        status_word[stat_done_bit] = done;
    end

    for (genvar i = 0; i < cells; i++) begin : g_wflat
        assign weights_flat[i*data_w +: data_w] = weight_bank[i];
    end

    // host-side banks
    always_ff @(posedge clk) begin
        if (wr_en && hit_w) begin
            weight_bank[w_off[cell_w-1:0]] <= wb_dat_w[data_w-1:0];  // PEs keep their own copy
        end
        if (wr_en && hit_x && !busy) begin
            input_bank[x_off[cell_w-1:0]] <= wb_dat_w[data_w-1:0];
        end
        if (xfer && !wb_we) begin
            if (wb_adr == reg_status) wb_dat_r <= status_word;
            else if (hit_w)           wb_dat_r <= bus_w'(weight_bank[w_off[cell_w-1:0]]);
            else if (hit_x)           wb_dat_r <= bus_w'(input_bank[x_off[cell_w-1:0]]);
            else if (hit_y)           wb_dat_r <= result_bank[y_off[cell_w-1:0]];
            else                      wb_dat_r <= '0;   // unmapped and ctrl read zero
        end
        for (int r = 0; r < n; r++) begin
            vec_data[r*data_w +: data_w] <= input_bank[int'(row_idx)*n + r];
        end
    end

    // results read as zero until the first run writes them
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < cells; i++) begin
                result_bank[i] <= '0;
            end
        end else if (res_valid) begin
            for (int c = 0; c < n; c++) begin
                result_bank[int'(res_idx)*n + c] <= res_data[c*acc_w +: acc_w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= idle;
            row_idx     <= '0;
            res_idx     <= '0;
            done        <= 1'b0;
            wb_ack      <= 1'b0;
            load_weight <= 1'b0;
            vec_valid   <= 1'b0;
        end else begin
            wb_ack      <= xfer;                 // one cycle after the transfer is seen
            load_weight <= load_cmd;
            vec_valid   <= (state == stream);    // vec_data is registered alongside
            if (res_valid) begin
                res_idx <= res_idx + 1'b1;
            end
            case (state)
                idle: begin
                    if (start_cmd) begin
                        state   <= stream;
                        row_idx <= '0;
                        res_idx <= '0;
                        done    <= 1'b0;
                    end
                end
                stream: begin
                    row_idx <= row_idx + 1'b1;
                    if (row_idx == idx_w'(n - 1)) state <= drain;
                end
                drain: begin
                    if (res_valid && res_idx == idx_w'(n - 1)) state <= finish;
                end
                finish: begin
                    state <= idle;               // busy falls as done rises
                    done  <= 1'b1;
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== operand_skewer.sv ====
module operand_skewer #(
    parameter int n = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              vec_valid,   // one activation row per cycle
    input  logic [n*systolic_pkg::data_w-1:0] vec_data,    // element r in lane r
    output logic [n-1:0]                      row_valid,   // to the array left edge
    output logic [n*systolic_pkg::data_w-1:0] row_data
);
    import systolic_pkg::*;

    // lane r is delayed by r cycles so the wavefront enters diagonally
    for (genvar r = 0; r < n; r++) begin : g_lane
        if (r == 0) begin : g_direct
            assign row_valid[0]        = vec_valid;          // no delay on lane 0
            assign row_data[0 +: data_w] = vec_data[0 +: data_w];
        end else begin : g_delay
            logic [data_w-1:0] data_q [r];   // r data stages
            logic [r-1:0]      valid_q;      // r valid stages

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    valid_q <= '0;
                end else begin
                    valid_q[0] <= vec_valid;
                    for (int i = 1; i < r; i++) begin
                        valid_q[i] <= valid_q[i-1];
                    end
                end
            end

            // data shifts every cycle, vectors overlap in flight
            always_ff @(posedge clk) begin
                data_q[0] <= vec_data[r*data_w +: data_w];
                for (int i = 1; i < r; i++) begin
                    data_q[i] <= data_q[i-1];
                end
            end

            assign row_valid[r]               = valid_q[r-1];
            assign row_data[r*data_w +: data_w] = data_q[r-1];
        end
    end

endmodule

// ==== result_deskewer.sv ====
module result_deskewer #(
    parameter int n = 2
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [n-1:0]                     col_valid,   // bottom row of the array
    input  logic [n*systolic_pkg::acc_w-1:0] col_psum,
    output logic                             res_valid,   // one aligned result row
    output logic [n*systolic_pkg::acc_w-1:0] res_data     // Y(k,c) in lane c
);
    import systolic_pkg::*;

    logic [acc_w-1:0] psum_m  [n];    // psums with idle beats forced to zero
    logic [n-2:0]     valid_q;        // column 0 valid, n-1 stages

    for (genvar c = 0; c < n; c++) begin : g_mask
        assign psum_m[c] = col_valid[c] ? col_psum[c*acc_w +: acc_w] : '0;
    end

    // column 0 finishes first and waits longest, so it sets the pace
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= col_valid[0];
            for (int i = 1; i < n - 1; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    assign res_valid = valid_q[n-2];

    // column c waits n-1-c cycles, mirror of the input skew
    for (genvar c = 0; c < n; c++) begin : g_col
        localparam int depth = n - 1 - c;

        if (depth == 0) begin : g_direct
            assign res_data[c*acc_w +: acc_w] = psum_m[c];   // last column is already late
        end else begin : g_delay
            logic [acc_w-1:0] data_q [depth];

            always_ff @(posedge clk) begin
                data_q[0] <= psum_m[c];
                for (int i = 1; i < depth; i++) begin
                    data_q[i] <= data_q[i-1];
                end
            end

            assign res_data[c*acc_w +: acc_w] = data_q[depth-1];
        end
    end

endmodule

// ==== systolic_array.sv ====
module systolic_array #(
    parameter int n = 2
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load_weight,   // latch weights_flat into all PEs
    input  logic [n*n*systolic_pkg::data_w-1:0] weights_flat,  // W(r,c) at index r*n + c
    input  logic [n-1:0]                        row_valid,     // left edge, already skewed
    input  logic [n*systolic_pkg::data_w-1:0]   row_data,
    output logic [n-1:0]                        col_valid,     // bottom edge
    output logic [n*systolic_pkg::acc_w-1:0]    col_psum
);
    import systolic_pkg::*;

    // horizontal links carry activation and valid, vertical links carry psums
    logic [data_w-1:0] act_h   [n][n+1];
    logic              valid_h [n][n+1];
    logic [acc_w-1:0]  psum_v  [n+1][n];

    for (genvar r = 0; r < n; r++) begin : g_left
        assign act_h[r][0]   = row_data[r*data_w +: data_w];  // lane r enters row r
        assign valid_h[r][0] = row_valid[r];
    end

    for (genvar c = 0; c < n; c++) begin : g_edge
        assign psum_v[0][c]              = '0;                    // top row starts from zero
        assign col_psum[c*acc_w +: acc_w] = psum_v[n][c];
        assign col_valid[c]              = valid_h[n-1][c+1];    // bottom-row valid out
    end

    for (genvar r = 0; r < n; r++) begin : g_row
        for (genvar c = 0; c < n; c++) begin : g_col
            systolic_pe pe_inst (
                .clk          (clk),
                .rst_n        (rst_n),
                .load_weight  (load_weight),
                .weight_in    (weights_flat[(r*n+c)*data_w +: data_w]),
                .pe_valid_in  (valid_h[r][c]),
                .act_in       (act_h[r][c]),
                .psum_in      (psum_v[r][c]),
                .pe_valid_out (valid_h[r][c+1]),   // to the right neighbour
                .act_out      (act_h[r][c+1]),
                .psum_out     (psum_v[r+1][c])     // down the column
            );
        end
    end

endmodule

// ==== systolic_assertions.sv ====
module systolic_assertions (
    input logic clk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic busy,          // controller run in flight
    input logic done,
    input logic load_weight
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned failures = 0;   // failed property count

    // ack only answers a transfer that was active on the previous edge
    ack_in_transfer: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            $error("wb_ack raised without an active transfer");
            failures++;
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack held for two cycles");
            failures++;
        end

    busy_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done))
        else begin
            $error("busy and done high together");
            failures++;
        end

    load_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        load_weight |=> !load_weight)
        else begin
            $error("load_weight longer than one cycle");
            failures++;
        end

endmodule

bind systolic_wb_top systolic_assertions assertions_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .busy        (ctrl_inst.busy),
    .done        (ctrl_inst.done),
    .load_weight (load_weight)
);

// ==== systolic_pe.sv ====
module systolic_pe (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load_weight,   // one-cycle strobe from controller
    input  logic [systolic_pkg::data_w-1:0] weight_in,
    input  logic                            pe_valid_in,
    input  logic [systolic_pkg::data_w-1:0] act_in,        // from the left neighbour
    input  logic [systolic_pkg::acc_w-1:0]  psum_in,       // from the PE above
    output logic                            pe_valid_out,
    output logic [systolic_pkg::data_w-1:0] act_out,       // to the right neighbour
    output logic [systolic_pkg::acc_w-1:0]  psum_out       // to the PE below
);
    import systolic_pkg::*;

    logic [data_w-1:0] weight_q;   // stationary weight, held between runs
    logic [acc_w-1:0]  product;    // act * weight, unsigned

    // both operands zero-extended so the product never overflows before the add
    assign product = acc_w'(act_in) * acc_w'(weight_q);

    // control state: weight and valid bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            weight_q     <= '0;             // PEs come up with zero weights
            pe_valid_out <= 1'b0;
        end else begin
            if (load_weight) begin
                weight_q <= weight_in;      // all PEs latch in the same cycle
            end
            pe_valid_out <= pe_valid_in;    // valid rides with the activation
        end
    end

    // payload: only advances on a valid beat
    always_ff @(posedge clk) begin
        if (pe_valid_in) begin
            act_out  <= act_in;             // pass activation to the right
            psum_out <= psum_in + product;  // accumulate mod 2^acc_w
        end
    end

endmodule

// ==== systolic_pkg.sv ====
package systolic_pkg;

    // element and accumulator widths
    localparam int data_w = 16;          // weight / activation element
    localparam int acc_w  = 32;          // partial sum and result, wraps mod 2^32

    // wishbone port widths
    localparam int bus_w = 32;           // data bus
    localparam int adr_w = 12;           // word address

    // register map, word addresses
    localparam logic [adr_w-1:0] reg_ctrl    = 12'h000;  // bit 0 start, bit 1 load weights
    localparam logic [adr_w-1:0] reg_status  = 12'h001;  // bit 0 busy, bit 1 done
    localparam logic [adr_w-1:0] base_weight = 12'h100;  // W(r,c) at base + r*n + c
    localparam logic [adr_w-1:0] base_input  = 12'h200;  // X(k,r) at base + k*n + r
    localparam logic [adr_w-1:0] base_result = 12'h300;  // Y(k,c) at base + k*n + c

    // control register fields
    localparam int ctrl_start_bit = 0;
    localparam int ctrl_load_bit  = 1;

    // status register fields
    localparam int stat_busy_bit = 0;
    localparam int stat_done_bit = 1;

    // run sequencer states
    typedef enum logic [1:0] {
        idle   = 2'd0,   // waiting for start
        stream = 2'd1,   // pushing activation rows into the skewer
        drain  = 2'd2,   // collecting result rows
        finish = 2'd3    // one cycle to raise done
    } ctrl_state_e;

endpackage

// ==== systolic_wb_top.sv ====
module systolic_wb_top #(
    parameter int n = 2
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [systolic_pkg::adr_w-1:0] wb_adr,
    input  logic [systolic_pkg::bus_w-1:0] wb_dat_w,
    output logic [systolic_pkg::bus_w-1:0] wb_dat_r,
    output logic                           wb_ack
);
    import systolic_pkg::*;

    logic                    load_weight;    // ctrl -> array
    logic [n*n*data_w-1:0]   weights_flat;
    logic                    vec_valid;      // ctrl -> skewer
    logic [n*data_w-1:0]     vec_data;
    logic [n-1:0]            row_valid;      // skewer -> array
    logic [n*data_w-1:0]     row_data;
    logic [n-1:0]            col_valid;      // array -> deskewer
    logic [n*acc_w-1:0]      col_psum;
    logic                    res_valid;      // deskewer -> ctrl
    logic [n*acc_w-1:0]      res_data;

    matmul_ctrl #(.n(n)) ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .load_weight  (load_weight),
        .weights_flat (weights_flat),
        .vec_valid    (vec_valid),
        .vec_data     (vec_data),
        .res_valid    (res_valid),
        .res_data     (res_data)
    );

    operand_skewer #(.n(n)) skewer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .vec_valid (vec_valid),
        .vec_data  (vec_data),
        .row_valid (row_valid),
        .row_data  (row_data)
    );

    systolic_array #(.n(n)) array_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_weight  (load_weight),
        .weights_flat (weights_flat),
        .row_valid    (row_valid),
        .row_data     (row_data),
        .col_valid    (col_valid),
        .col_psum     (col_psum)
    );

    result_deskewer #(.n(n)) deskewer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .col_valid (col_valid),
        .col_psum  (col_psum),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

endmodule

// ==== tb_systolic.sv ====
module tb_systolic;
    timeunit 1ns;
    timeprecision 1ps;
    import systolic_pkg::*;

    localparam int n         = 2;
    localparam int cells     = n * n;
    localparam int max_polls = 20;                            // status reads per run
    localparam int runs      = 9;                             // starts over all tests
    localparam int run_txn   = 3 * cells + 2 + max_polls;     // W, load, X, start, polls, Y
    localparam int total_txn = runs * run_txn + 4 * cells + 12;
    localparam int limit_cyc = total_txn * 20 + runs * 200 + 16;

    logic             clk;
    logic             rst_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [adr_w-1:0] wb_adr;
    logic [bus_w-1:0] wb_dat_w;
    logic [bus_w-1:0] wb_dat_r;
    logic             wb_ack;

    logic [data_w-1:0] w_tb  [cells];     // weight bank as written
    logic [data_w-1:0] w_pe  [cells];     // copy latched by the PEs
    logic [data_w-1:0] x_tb  [cells];     // activation bank
    logic [acc_w-1:0]  y_ref [cells];     // expected result bank
    logic [31:0]       rng_state = 32'd15;
    int                errors = 0;
    int                checks = 0;
    int                mark;              // error count at test start

    systolic_wb_top #(.n(n)) systolic_wb_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;            // 4 ns period
    end

    initial begin
        repeat (limit_cyc) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", limit_cyc);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic wb_write(input logic [adr_w-1:0] adr, input logic [bus_w-1:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        do @(negedge clk); while (!wb_ack);   // hold until ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);                       // idle cycle between transfers
    endtask

    task automatic wb_read(input logic [adr_w-1:0] adr, output logic [bus_w-1:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do @(negedge clk); while (!wb_ack);
        data   = wb_dat_r;                    // valid alongside ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge clk);
    endtask

    task automatic write_weights();
        for (int i = 0; i < cells; i++) wb_write(base_weight + adr_w'(i), bus_w'(w_tb[i]));
    endtask

    task automatic load_weights();
        wb_write(reg_ctrl, bus_w'(1) << ctrl_load_bit);
        foreach (w_tb[i]) w_pe[i] = w_tb[i];  // PEs now hold the staged bank
    endtask

    task automatic write_inputs();
        for (int i = 0; i < cells; i++) wb_write(base_input + adr_w'(i), bus_w'(x_tb[i]));
    endtask

    task automatic start_run();
        wb_write(reg_ctrl, bus_w'(1) << ctrl_start_bit);
    endtask

    task automatic wait_done();
        logic [bus_w-1:0] st;
        int               polls;
        polls = 0;
        do begin
            wb_read(reg_status, st);
            polls++;
        end while (!st[stat_done_bit] && polls < max_polls);
        if (!st[stat_done_bit]) begin
            $display("run did not report done after %0d status polls", polls);
            errors++;
        end else begin
            check_value("status", st, 32'h2);    // done set, busy clear
        end
    endtask

    task automatic run_matmul();
        start_run();
        wait_done();
    endtask

    task automatic randomize_weights();
        foreach (w_tb[i]) w_tb[i] = data_w'(next_random());
    endtask

    task automatic randomize_inputs();
        foreach (x_tb[i]) x_tb[i] = data_w'(next_random());
    endtask

    // Y(k,c) = sum over r of X(k,r) * W(r,c), wraps at 32 bits
    task automatic compute_reference();
        logic [acc_w-1:0] sum;
        for (int k = 0; k < n; k++) begin
            for (int c = 0; c < n; c++) begin
                sum = '0;
                for (int r = 0; r < n; r++) begin
                    sum = sum + acc_w'(x_tb[k*n + r]) * acc_w'(w_pe[r*n + c]);
                end
                y_ref[k*n + c] = sum;
            end
        end
    endtask

    task automatic check_results();
        logic [bus_w-1:0] d;
        for (int i = 0; i < cells; i++) begin
            wb_read(base_result + adr_w'(i), d);
            check_value($sformatf("Y[%0d][%0d]", i / n, i % n), d, y_ref[i]);
        end
    endtask

    task automatic report_test(input string name);
        $display("%-24s %s (%0d errors)", name, (errors == mark) ? "pass" : "fail",
                 errors - mark);
    endtask

    task automatic test_reset_state();
        logic [bus_w-1:0] d;
        mark = errors;
        wb_read(reg_status, d);
        check_value("status", d, '0);
        wb_read(reg_ctrl, d);
        check_value("ctrl", d, '0);          // ctrl has no read-back
        for (int i = 0; i < cells; i++) begin
            wb_read(base_result + adr_w'(i), d);
            check_value($sformatf("Y[%0d][%0d]", i / n, i % n), d, '0);
        end
        wb_read(12'h0F0, d);
        check_value("unmapped 0x0f0", d, '0);
        wb_read(12'h1FF, d);                 // past the weight bank
        check_value("unmapped 0x1ff", d, '0);
        wb_read(12'hFFF, d);
        check_value("unmapped 0xfff", d, '0);
        report_test("reset state");
    endtask

    task automatic test_identity();
        mark = errors;
        foreach (w_tb[i]) w_tb[i] = (i / n == i % n) ? data_w'(1) : '0;
        write_weights();
        load_weights();
        randomize_inputs();
        write_inputs();
        run_matmul();
        foreach (y_ref[i]) y_ref[i] = acc_w'(x_tb[i]);   // identity passes X through
        check_results();
        report_test("identity weights");
    endtask

    task automatic test_random_runs();
        mark = errors;
        repeat (3) begin
            randomize_weights();
            write_weights();
            load_weights();
            randomize_inputs();
            write_inputs();
            run_matmul();
            compute_reference();
            check_results();
        end
        report_test("random products");
    endtask

    task automatic test_unloaded_weights();
        logic [bus_w-1:0] d;
        mark = errors;
        randomize_weights();
        write_weights();
        load_weights();
        randomize_inputs();
        write_inputs();
        start_run();
        wb_read(reg_status, d);
        check_value("status", d, 32'h1);     // busy, done cleared by start
        w_tb[cells-1] = ~w_tb[cells-1];      // staged only, PEs keep the old value
        wb_write(base_weight + adr_w'(cells - 1), bus_w'(w_tb[cells-1]));
        wait_done();
        compute_reference();                 // still on w_pe
        check_results();
        load_weights();
        run_matmul();
        compute_reference();
        check_results();
        report_test("weights staged mid-run");
    endtask

    task automatic test_busy_ignored();
        logic [bus_w-1:0]  d;
        logic [data_w-1:0] alt;
        mark = errors;
        randomize_weights();
        write_weights();
        load_weights();
        randomize_inputs();
        write_inputs();
        alt = ~x_tb[0];
        start_run();
        wb_write(base_input, bus_w'(alt));   // lands while busy, dropped
        start_run();                         // second start, dropped
        wait_done();
        wb_read(base_input, d);
        check_value("X[0][0]", d, bus_w'(x_tb[0]));
        compute_reference();
        check_results();
        repeat (3) begin                     // no second run follows
            wb_read(reg_status, d);
            check_value("status", d, 32'h2);
        end
        report_test("writes while busy");
    endtask

    task automatic test_reload_no_run();
        mark = errors;
        randomize_weights();
        write_weights();
        load_weights();
        randomize_inputs();
        write_inputs();
        run_matmul();
        compute_reference();
        check_results();
        randomize_weights();
        write_weights();
        load_weights();
        check_results();                     // y_ref from the previous run
        run_matmul();
        compute_reference();
        check_results();
        report_test("reload without run");
    endtask

    initial begin
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        foreach (w_pe[i]) w_pe[i] = '0;      // PEs reset to zero weights
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_identity();
        test_random_runs();
        test_unloaded_weights();
        test_busy_ignored();
        test_reload_no_run();
        errors += int'(systolic_wb_top_inst.assertions_inst.failures);  // bound protocol checks
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
